// ==== logic/wb_bus_pkg.sv ====
package wb_bus_pkg;

    // bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned SEL_W  = DATA_W / 8;   // one lane per byte

    // address split as the ram sees it
    localparam int unsigned BYTE_OFS_W = 2;                           // ignored, word access only
    localparam int unsigned WORD_IDX_W = 8;                           // 256 words
    localparam int unsigned REGION_W   = ADDR_W - WORD_IDX_W - BYTE_OFS_W; // must be zero for ram

    typedef struct packed {
        logic [REGION_W-1:0]   region;
        logic [WORD_IDX_W-1:0] word;
        logic [BYTE_OFS_W-1:0] byte_ofs;
    } wb_addr_fields_t;

    // same 32 bits, flat or split
    typedef union packed {
        logic [ADDR_W-1:0] raw;     // flat address, passed through the mux untouched
        wb_addr_fields_t   fields;  // decoded view for the slave
    } wb_addr_u;

    // request from one manager, or the one forwarded to the slave
    typedef struct packed {
        wb_addr_u          adr;
        logic [DATA_W-1:0] dat;   // write data
        logic [SEL_W-1:0]  sel;   // byte enables
        logic              we;
        logic              stb;
        logic              cyc;
    } wb_req_t;

    // response seen by one manager
    typedef struct packed {
        logic [DATA_W-1:0] dat;   // read data, valid with ack
        logic              ack;
        logic              err;   // timeout, never from the ram itself
    } wb_rsp_t;

endpackage

// ==== logic/arb_cfg_pkg.sv ====
package arb_cfg_pkg;

    // subsystem sizes
    localparam int unsigned NUM_MANAGERS   = 3;
    localparam int unsigned TIMEOUT_CYCLES = 16;   // granted cycles without ack before err
    localparam int unsigned TIMER_W        = 5;
    localparam int unsigned RAM_WORDS      = 256;

    // count value that flags expiry, reached on the last allowed cycle
    localparam logic [TIMER_W-1:0] TIMEOUT_LAST = TIMER_W'(TIMEOUT_CYCLES - 1);

    // one-hot arbiter state, bit 0 is idle, bit i+1 is manager i
    localparam int unsigned STATE_W = NUM_MANAGERS + 1;
    localparam logic [STATE_W-1:0] STATE_IDLE = STATE_W'(1);

endpackage

// ==== logic/wb_arbiter_fsm.sv ====
`timescale 1ns/1ps

module wb_arbiter_fsm (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  wb_bus_pkg::wb_req_t [arb_cfg_pkg::NUM_MANAGERS-1:0] mgr_req,
    input  logic                                                slv_rsp_ack,
    input  logic                                                expired,
    output logic [arb_cfg_pkg::NUM_MANAGERS-1:0]                grant,
    output logic                                                timer_run
);

    logic [arb_cfg_pkg::STATE_W-1:0] state_q;   // one-hot, bit 0 = idle
    logic [arb_cfg_pkg::STATE_W-1:0] state_d;
    logic                            done;      // transaction ends this cycle

    assign done = slv_rsp_ack | expired;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= arb_cfg_pkg::STATE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // next state and grant
    always_comb begin
        state_d   = state_q;
        grant     = '0;
        timer_run = 1'b0;

        if (state_q[0]) begin
            // idle: pick a requester this very cycle (mealy)
            // walk from the top down so the lowest index is written last and wins
            for (int i = arb_cfg_pkg::NUM_MANAGERS - 1; i >= 0; i--) begin
                if (mgr_req[i].stb && mgr_req[i].cyc) begin
                    grant          = '0;
                    grant[i]       = 1'b1;
                    state_d        = '0;
                    state_d[i + 1] = 1'b1;   // remember who owns the bus
                end
            end
        end else begin
            // a manager owns the bus, hold its grant until ack or timeout
            grant     = state_q[arb_cfg_pkg::STATE_W-1:1];
            timer_run = 1'b1;
            if (done) begin
                state_d = arb_cfg_pkg::STATE_IDLE;   // back to idle, re-arbitrate next cycle
            end
        end
    end

endmodule

// ==== logic/bus_timeout_timer.sv ====
`timescale 1ns/1ps

module bus_timeout_timer (
    input  logic CLK,
    input  logic nRST,
    input  logic run,       // high while a manager holds the bus
    output logic expired
);

    logic [arb_cfg_pkg::TIMER_W-1:0] count_q;   // cycles spent in the current grant

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            count_q <= '0;
        end else if (!run) begin
            count_q <= '0;                      // idle clears it
        end else if (count_q != '1) begin
            count_q <= count_q + 1'b1;          // saturate at all ones
        end
    end

    // last allowed cycle, fsm drops the grant at the next edge
    assign expired = run && (count_q == arb_cfg_pkg::TIMEOUT_LAST);

endmodule

// ==== logic/wb_grant_mux.sv ====
`timescale 1ns/1ps

module wb_grant_mux (
    input  wb_bus_pkg::wb_req_t [arb_cfg_pkg::NUM_MANAGERS-1:0] mgr_req,
    input  logic [arb_cfg_pkg::NUM_MANAGERS-1:0]                grant,     // one-hot or empty
    input  wb_bus_pkg::wb_rsp_t                                 slv_rsp,
    input  logic                                                bus_err,   // timeout expiry
    output wb_bus_pkg::wb_req_t                                 slv_req,
    output wb_bus_pkg::wb_rsp_t [arb_cfg_pkg::NUM_MANAGERS-1:0] mgr_rsp
);

    // request path, manager to slave
    always_comb begin
        slv_req = '0;   // nothing granted means no stb/cyc on the slave side
        for (int i = 0; i < arb_cfg_pkg::NUM_MANAGERS; i++) begin
            if (grant[i]) begin
                slv_req = mgr_req[i];   // whole request, address union passed as is
            end
        end
    end

    // response path, slave back to the owner only
    always_comb begin
        for (int i = 0; i < arb_cfg_pkg::NUM_MANAGERS; i++) begin
            mgr_rsp[i] = '0;   // losers see zeros
            if (grant[i]) begin
                mgr_rsp[i].dat = slv_rsp.dat;
                mgr_rsp[i].ack = slv_rsp.ack;
                mgr_rsp[i].err = slv_rsp.err | bus_err;   // ram err is tied low
            end
        end
    end

endmodule

// ==== logic/wb_ram_slave.sv ====
`timescale 1ns/1ps

module wb_ram_slave (
    input  logic                CLK,
    input  logic                nRST,
    input  wb_bus_pkg::wb_req_t slv_req,
    output wb_bus_pkg::wb_rsp_t slv_rsp
);

    logic [wb_bus_pkg::DATA_W-1:0]     mem [arb_cfg_pkg::RAM_WORDS];
    logic [wb_bus_pkg::WORD_IDX_W-1:0] word_idx;
    logic                              in_region;   // upper address bits all zero
    logic                              accept;      // new request taken this cycle
    logic                              ack_q;
    logic [wb_bus_pkg::DATA_W-1:0]     rdata_q;

    assign word_idx  = slv_req.adr.fields.word;
    assign in_region = (slv_req.adr.fields.region == '0);

    // ack low means this is a fresh request, not the held one we just acked
    assign accept = slv_req.stb && slv_req.cyc && in_region && !ack_q;

    // ack and read data are registered, one cycle after accept
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q <= accept;   // single cycle pulse
            if (accept && !slv_req.we) begin
                rdata_q <= mem[word_idx];
            end
        end
    end

    // storage, byte lanes written at the same edge that raises ack
    always_ff @(posedge CLK) begin
        if (accept && slv_req.we) begin
            for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
                if (slv_req.sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= slv_req.dat[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        slv_rsp     = '0;
        slv_rsp.dat = rdata_q;
        slv_rsp.ack = ack_q;
        slv_rsp.err = 1'b0;   // out of region is left to the timeout
    end

endmodule

// ==== logic/wb_shared_ram.sv ====
`timescale 1ns/1ps

module wb_shared_ram (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  wb_bus_pkg::wb_req_t [arb_cfg_pkg::NUM_MANAGERS-1:0] mgr_req,
    output wb_bus_pkg::wb_rsp_t [arb_cfg_pkg::NUM_MANAGERS-1:0] mgr_rsp
);

    wb_bus_pkg::wb_req_t                  slv_req;     // granted request to the ram
    wb_bus_pkg::wb_rsp_t                  slv_rsp;     // ram response
    logic [arb_cfg_pkg::NUM_MANAGERS-1:0] grant;       // one-hot owner
    logic                                 timer_run;   // a manager holds the bus
    logic                                 expired;     // timeout, ends the transaction

    // owner selection
    wb_arbiter_fsm arbiter_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .mgr_req     (mgr_req),
        .slv_rsp_ack (slv_rsp.ack),
        .expired     (expired),
        .grant       (grant),
        .timer_run   (timer_run)
    );

    // watches the granted transaction
    bus_timeout_timer timer_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .run     (timer_run),
        .expired (expired)
    );

    // steering both ways, err goes to the owner only
    wb_grant_mux mux_inst (
        .mgr_req (mgr_req),
        .grant   (grant),
        .slv_rsp (slv_rsp),
        .bus_err (expired),
        .slv_req (slv_req),
        .mgr_rsp (mgr_rsp)
    );

    wb_ram_slave ram_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .slv_req (slv_req),
        .slv_rsp (slv_rsp)
    );

endmodule

// ==== sim/tb_wb_shared_ram.sv ====
`timescale 1ns/1ps

module tb_wb_shared_ram;

    localparam int NM            = arb_cfg_pkg::NUM_MANAGERS;
    localparam int NUM_DIRECTED  = 9;
    localparam int NUM_RANDOM    = 12;
    localparam int NUM_ENTRIES   = NUM_DIRECTED + NUM_RANDOM;
    localparam int TOTAL_ENTRIES = arb_cfg_pkg::RAM_WORDS + NUM_ENTRIES;   // fill writes count too
    localparam int WATCHDOG_CYCLES =
        TOTAL_ENTRIES * NM * (arb_cfg_pkg::TIMEOUT_CYCLES + 4) + 50;

    // one manager's part of a table entry
    typedef struct packed {
        logic                          we;
        logic [wb_bus_pkg::ADDR_W-1:0] adr;
        logic [wb_bus_pkg::DATA_W-1:0] dat;
        logic [wb_bus_pkg::SEL_W-1:0]  sel;
    } mgr_op_t;

    typedef struct packed {
        logic [NM-1:0]    mask;   // which managers request in this entry
        mgr_op_t [NM-1:0] op;
    } entry_t;

    logic                                CLK;
    logic                                nRST;
    wb_bus_pkg::wb_req_t [NM-1:0]        mgr_req;
    wb_bus_pkg::wb_rsp_t [NM-1:0]        mgr_rsp;

    entry_t                              table_q [NUM_ENTRIES];
    logic [wb_bus_pkg::DATA_W-1:0]       ref_mem [arb_cfg_pkg::RAM_WORDS];   // reference words
    logic [15:0]                         lfsr_q;
    int                                  check_count;
    int                                  error_count;

    wb_shared_ram wb_shared_ram_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .mgr_req (mgr_req),
        .mgr_rsp (mgr_rsp)
    );

    always #2 CLK = ~CLK;   // 4 ns period

    // x^16 + x^14 + x^13 + x^11 + 1, new bit shifted in at the bottom
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $realtime, what, got, exp);
            error_count++;
        end
    endtask

    function automatic mgr_op_t make_op(input logic we, input logic [31:0] adr,
                                        input logic [31:0] dat, input logic [3:0] sel);
        mgr_op_t o;
        o.we  = we;
        o.adr = adr;
        o.dat = dat;
        o.sel = sel;
        return o;
    endfunction

    // preload pattern, every bit of the word index shows up
    function automatic logic [31:0] fill_word(input logic [7:0] w);
        return {~w, w ^ 8'h5A, {w[3:0], w[7:4]}, w + 8'h31};
    endfunction

    task automatic build_table();
        logic [31:0] v;
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            table_q[n] = '0;
        end
        // full word write, then read back from the same manager
        table_q[0].mask  = 3'b001;
        table_q[0].op[0] = make_op(1'b1, 32'h0000_0010, 32'hDEAD_BEEF, 4'hF);
        table_q[1].mask  = 3'b001;
        table_q[1].op[0] = make_op(1'b0, 32'h0000_0010, 32'h0, 4'h0);
        // lanes 0 and 2 only, read by another manager
        table_q[2].mask  = 3'b010;
        table_q[2].op[1] = make_op(1'b1, 32'h0000_0010, 32'h1122_3344, 4'b0101);
        table_q[3].mask  = 3'b100;
        table_q[3].op[2] = make_op(1'b0, 32'h0000_0010, 32'h0, 4'h0);
        // all three at once, served 0, 1, 2
        table_q[4].mask  = 3'b111;
        table_q[4].op[0] = make_op(1'b1, 32'h0000_0020, 32'hA5A5_A5A5, 4'hF);
        table_q[4].op[1] = make_op(1'b0, 32'h0000_0020, 32'h0, 4'h0);
        table_q[4].op[2] = make_op(1'b1, 32'h0000_0024, 32'h1234_5678, 4'b1100);
        table_q[5].mask  = 3'b111;
        table_q[5].op[0] = make_op(1'b0, 32'h0000_0024, 32'h0, 4'h0);
        table_q[5].op[1] = make_op(1'b1, 32'h0000_0024, 32'hCAFE_F00D, 4'b0011);
        table_q[5].op[2] = make_op(1'b0, 32'h0000_0024, 32'h0, 4'h0);
        // region nonzero, ends on the timeout
        table_q[6].mask  = 3'b010;
        table_q[6].op[1] = make_op(1'b0, 32'h0001_0010, 32'h0, 4'h0);
        table_q[7].mask  = 3'b101;
        table_q[7].op[0] = make_op(1'b1, 32'h0000_0080, 32'h0BAD_F00D, 4'hF);
        table_q[7].op[2] = make_op(1'b0, 32'h0000_0080, 32'h0, 4'h0);
        // timeout in the middle of a busy entry
        table_q[8].mask  = 3'b111;
        table_q[8].op[0] = make_op(1'b0, 32'h0000_0020, 32'h0, 4'h0);
        table_q[8].op[1] = make_op(1'b1, 32'h4000_0000, 32'h5555_AAAA, 4'hF);
        table_q[8].op[2] = make_op(1'b0, 32'h0000_0010, 32'h0, 4'h0);

        for (int n = NUM_DIRECTED; n < NUM_ENTRIES; n++) begin
            take_bits(NM, v);
            while (v[NM-1:0] == '0) begin
                take_bits(NM, v);   // at least one requester
            end
            table_q[n].mask = v[NM-1:0];
            for (int m = 0; m < NM; m++) begin
                take_bits(1, v);
                table_q[n].op[m].we  = v[0];
                take_bits(8, v);
                table_q[n].op[m].adr = {22'b0, v[7:0], 2'b00};   // always in region
                take_bits(32, v);
                table_q[n].op[m].dat = v;
                take_bits(4, v);
                table_q[n].op[m].sel = v[3:0];
            end
        end
    endtask

    // drives one entry and checks every manager's response each cycle
    task automatic run_entry(input entry_t e);
        logic [7:0]    word;
        logic [31:0]   exp_rdata [NM];
        logic          in_reg [NM];
        int            exp_cycle [NM];
        int            grant_cycle [NM];
        int            next_grant;
        int            cycle;
        logic [NM-1:0] pending;
        logic [NM-1:0] drop;
        logic          exp_ack;
        logic          exp_err;

        // expected order, timing and data, lowest index first
        next_grant = 0;
        for (int i = 0; i < NM; i++) begin
            in_reg[i]      = (e.op[i].adr[31:10] == '0);
            exp_rdata[i]   = '0;
            exp_cycle[i]   = -1;
            grant_cycle[i] = -1;
            if (e.mask[i]) begin
                word = e.op[i].adr[9:2];
                grant_cycle[i] = next_grant;   // owns the bus from here on
                exp_cycle[i] = in_reg[i] ? next_grant + 1
                                         : next_grant + int'(arb_cfg_pkg::TIMEOUT_CYCLES);
                next_grant = exp_cycle[i] + 1;   // next one granted right after
                if (in_reg[i] && e.op[i].we) begin
                    for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
                        if (e.op[i].sel[b]) ref_mem[word][b*8 +: 8] = e.op[i].dat[b*8 +: 8];
                    end
                end else if (in_reg[i]) begin
                    exp_rdata[i] = ref_mem[word];
                end
            end
        end

        @(posedge CLK);
        #1;
        for (int i = 0; i < NM; i++) begin
            mgr_req[i] = '0;
            if (e.mask[i]) begin
                mgr_req[i].adr.raw = e.op[i].adr;
                mgr_req[i].dat     = e.op[i].dat;
                mgr_req[i].sel     = e.op[i].sel;
                mgr_req[i].we      = e.op[i].we;
                mgr_req[i].stb     = 1'b1;
                mgr_req[i].cyc     = 1'b1;
            end
        end
        pending = e.mask;
        cycle   = 0;

        while (pending != '0) begin
            @(negedge CLK);   // outputs settled mid cycle
            drop = '0;
            for (int i = 0; i < NM; i++) begin
                exp_ack = pending[i] && in_reg[i] && (cycle == exp_cycle[i]);
                exp_err = pending[i] && !in_reg[i] && (cycle == exp_cycle[i]);
                check_value($sformatf("m%0d ack, cycle %0d", i, cycle),
                            32'(mgr_rsp[i].ack), 32'(exp_ack));
                check_value($sformatf("m%0d err, cycle %0d", i, cycle),
                            32'(mgr_rsp[i].err), 32'(exp_err));
                if (!pending[i] || cycle < grant_cycle[i]) begin
                    // not the owner, data must stay zero
                    check_value($sformatf("m%0d data while not owner, cycle %0d", i, cycle),
                                mgr_rsp[i].dat, 32'd0);
                end
                if (pending[i] && (mgr_rsp[i].ack || mgr_rsp[i].err)) begin
                    if (mgr_rsp[i].ack && !e.op[i].we) begin
                        check_value($sformatf("m%0d read data", i), mgr_rsp[i].dat,
                                    exp_rdata[i]);
                    end
                    drop[i] = 1'b1;   // released in the next cycle
                end
            end
            @(posedge CLK);
            #1;
            for (int i = 0; i < NM; i++) begin
                if (drop[i]) mgr_req[i] = '0;
            end
            pending = pending & ~drop;
            cycle++;
        end
    endtask

    initial begin
        CLK         = 1'b0;
        nRST        = 1'b0;
        mgr_req     = '0;
        lfsr_q      = 16'd37;
        check_count = 0;
        error_count = 0;
        build_table();

        repeat (10) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // nothing requested, nothing answered
        repeat (5) begin
            @(negedge CLK);
            for (int i = 0; i < NM; i++) begin
                check_value($sformatf("m%0d ack at idle", i), 32'(mgr_rsp[i].ack), 32'd0);
                check_value($sformatf("m%0d err at idle", i), 32'(mgr_rsp[i].err), 32'd0);
            end
        end
        $display("idle after reset: %s", (error_count == 0) ? "ok" : "mismatch");

        // preload every word so any later read has a known value
        for (int w = 0; w < arb_cfg_pkg::RAM_WORDS; w++) begin
            entry_t fill_e;
            fill_e              = '0;
            fill_e.mask[w % NM] = 1'b1;   // spread over all managers
            fill_e.op[w % NM]   = make_op(1'b1, 32'(w) << 2, fill_word(8'(w)), 4'hF);
            run_entry(fill_e);
        end
        $display("ram fill, %0d words: %s", arb_cfg_pkg::RAM_WORDS,
                 (error_count == 0) ? "ok" : "mismatch");

        for (int n = 0; n < NUM_ENTRIES; n++) begin
            int errs_before;
            errs_before = error_count;
            run_entry(table_q[n]);
            $display("entry %0d mask %b: %s", n, table_q[n].mask,
                     (error_count == errs_before) ? "ok" : "mismatch");
        end

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // bound on the whole run, worst case every transaction times out
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("run timed out after %0d cycles, a response never came", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== files.f ====
logic/wb_bus_pkg.sv
logic/arb_cfg_pkg.sv
logic/wb_arbiter_fsm.sv
logic/bus_timeout_timer.sv
logic/wb_grant_mux.sv
logic/wb_ram_slave.sv
logic/wb_shared_ram.sv
sim/tb_wb_shared_ram.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator, run, then look for the failure line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_wb_shared_ram \
    -f files.f \
    -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "Testbench failed" sim.log \
    && { echo "simulation reported errors"; exit 1; } \
    || { echo "simulation clean"; exit 0; }
